// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
  input  core_pkg::alu_op_e alu_op,
  input  core_pkg::word_t   a,
  input  core_pkg::word_t   b,
  output core_pkg::word_t   result
);
  import core_pkg::*;

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  assign shamt       = b[SHAMT_W-1:0];          // Upper bits of b ignored
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  // --------------------------------------------------
  // Result select
  // --------------------------------------------------
  always_comb begin
    case (alu_op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = {{(XLEN-1){1'b0}}, lt_signed};     // 0 or 1
      alu_sltu:   result = {{(XLEN-1){1'b0}}, lt_unsigned};
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = word_t'($signed(a) >>> shamt);     // Sign fill
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;                                 // lui
      default:    result = '0;
    endcase
  end

endmodule

// ==== core_pkg.sv ====
package core_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;                 // x0..x31
  localparam int SHAMT_W    = 5;                  // Shift amount bits of operand B

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Fetch constants
  localparam word_t RESET_PC = 32'h0000_0000;
  localparam word_t PC_STEP  = 32'd4;             // No branches, PC only steps

  // addi x0, x0, 0
  localparam word_t NOP_WORD = 32'h0000_0013;

  // --------------------------------------------------
  // Major opcodes kept from RV32I
  // --------------------------------------------------
  typedef enum logic [6:0] {
    op_reg   = 7'b0110011,                        // R-type ALU
    op_imm   = 7'b0010011,                        // I-type ALU
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111
  } opcode_e;

  // funct3 of the ALU group
  localparam logic [2:0] F3_ADD  = 3'b000;        // add, sub, addi
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;        // srl, sra and the imm forms
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct7 that flips add to sub and srl to sra
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  // --------------------------------------------------
  // ALU operations
  // --------------------------------------------------
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b                                    // lui, result is the immediate
  } alu_op_e;

endpackage

// ==== core_top.sv ====
`timescale 1ns/1ps

module core_top (
  input  logic                clock,
  input  logic                reset,
  output core_pkg::word_t     ins_mem_addr,
  input  core_pkg::word_t     ins_mem_data,
  output logic                retire_valid,
  output core_pkg::reg_addr_t retire_rd,
  output core_pkg::word_t     retire_data,
  output core_pkg::word_t     retire_pc
);
  import core_pkg::*;

  // IF/ID
  logic      if_valid;
  word_t     if_pc;
  word_t     if_instr;

  // Register file read
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;

  // ID/EX
  logic      ex_valid;
  reg_addr_t ex_rd;
  logic      ex_write;
  alu_op_e   ex_alu_op;
  logic      ex_sel_pc;
  logic      ex_sel_imm;
  logic      ex_fwd_a;
  logic      ex_fwd_b;
  word_t     ex_rs1_data;
  word_t     ex_rs2_data;
  word_t     ex_imm;
  word_t     ex_pc;

  // EX/WB
  logic      wb_write;
  reg_addr_t wb_rd;
  word_t     wb_data;

  // --------------------------------------------------
  // Stages
  // --------------------------------------------------
  fetch_unit u_fetch (
    .clock, .reset, .ins_mem_data, .ins_mem_addr,
    .if_valid, .if_pc, .if_instr
  );

  register_file u_regs (
    .clock, .reset, .rs1_addr, .rs2_addr,
    .wb_write, .wb_rd, .wb_data, .rs1_data, .rs2_data
  );

  decode_unit u_decode (
    .clock, .reset, .if_valid, .if_pc, .if_instr, .rs1_data, .rs2_data,
    .rs1_addr, .rs2_addr, .ex_valid, .ex_rd, .ex_write, .ex_alu_op,
    .ex_sel_pc, .ex_sel_imm, .ex_fwd_a, .ex_fwd_b,
    .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_pc
  );

  execute_unit u_execute (
    .clock, .reset, .ex_valid, .ex_rd, .ex_write, .ex_alu_op,
    .ex_sel_pc, .ex_sel_imm, .ex_fwd_a, .ex_fwd_b,
    .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_pc,
    .wb_write, .wb_rd, .wb_data,
    .retire_valid, .retire_rd, .retire_data, .retire_pc
  );

endmodule

// ==== decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
  input  logic                clock,
  input  logic                reset,
  input  logic                if_valid,
  input  core_pkg::word_t     if_pc,
  input  core_pkg::word_t     if_instr,
  input  core_pkg::word_t     rs1_data,       // From register file, write-through
  input  core_pkg::word_t     rs2_data,
  output core_pkg::reg_addr_t rs1_addr,
  output core_pkg::reg_addr_t rs2_addr,
  output logic                ex_valid,
  output core_pkg::reg_addr_t ex_rd,
  output logic                ex_write,
  output core_pkg::alu_op_e   ex_alu_op,
  output logic                ex_sel_pc,      // Operand A is PC
  output logic                ex_sel_imm,     // Operand B is immediate
  output logic                ex_fwd_a,       // Take wb_data for rs1
  output logic                ex_fwd_b,       // Take wb_data for rs2
  output core_pkg::word_t     ex_rs1_data,
  output core_pkg::word_t     ex_rs2_data,
  output core_pkg::word_t     ex_imm,
  output core_pkg::word_t     ex_pc
);
  import core_pkg::*;

  word_t      instr;
  opcode_e    opcode;
  logic [2:0] funct3;
  logic       funct7_alt;
  reg_addr_t  rd;
  logic       known_op;
  logic       use_rs1;
  logic       use_rs2;
  logic       wr_en;
  logic       sel_pc;
  logic       sel_imm;
  logic       fwd_a;
  logic       fwd_b;
  alu_op_e    alu_op;
  word_t      imm;

  // funct3 to ALU op, sub only exists in the register form
  function automatic alu_op_e alu_from_funct(logic [2:0] f3, logic alt, logic is_reg);
    alu_op_e op;
    case (f3)
      F3_ADD:  op = (alt && is_reg) ? alu_sub : alu_add;
      F3_SLL:  op = alu_sll;
      F3_SLT:  op = alu_slt;
      F3_SLTU: op = alu_sltu;
      F3_XOR:  op = alu_xor;
      F3_SR:   op = alt ? alu_sra : alu_srl;  // srai carries the same funct7
      F3_OR:   op = alu_or;
      F3_AND:  op = alu_and;
    endcase
    return op;
  endfunction

  // --------------------------------------------------
  // Field extract
  // --------------------------------------------------
  assign instr      = if_valid ? if_instr : NOP_WORD;   // Empty slot decodes as nop
  assign opcode     = opcode_e'(instr[6:0]);
  assign funct3     = instr[14:12];
  assign funct7_alt = (instr[31:25] == FUNCT7_ALT);
  assign rd         = instr[11:7];

  // Unused source fields read x0
  assign rs1_addr = use_rs1 ? instr[19:15] : '0;
  assign rs2_addr = use_rs2 ? instr[24:20] : '0;

  // Opcode decode and immediate
  always_comb begin
    known_op = 1'b1;
    use_rs1  = 1'b0;
    use_rs2  = 1'b0;
    sel_pc   = 1'b0;
    sel_imm  = 1'b1;
    alu_op   = alu_add;
    imm      = {{20{instr[31]}}, instr[31:20]};   // I-type by default
    case (opcode)
      op_reg: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        sel_imm = 1'b0;
        alu_op  = alu_from_funct(funct3, funct7_alt, 1'b1);
      end
      op_imm: begin
        use_rs1 = 1'b1;
        alu_op  = alu_from_funct(funct3, funct7_alt, 1'b0);
      end
      op_lui: begin
        imm    = {instr[31:12], 12'h000};
        alu_op = alu_pass_b;
      end
      op_auipc: begin
        imm    = {instr[31:12], 12'h000};
        sel_pc = 1'b1;                            // pc + imm
      end
      default: known_op = 1'b0;                   // Bubble, writes nothing
    endcase
  end

  assign wr_en = if_valid && known_op && (rd != '0);

  // Instruction now in execute produces the value one cycle later
  assign fwd_a = use_rs1 && ex_write && (ex_rd != '0) && (ex_rd == rs1_addr);
  assign fwd_b = use_rs2 && ex_write && (ex_rd != '0) && (ex_rd == rs2_addr);

  // --------------------------------------------------
  // ID/EX register
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid <= 1'b0;
      ex_write <= 1'b0;
      ex_fwd_a <= 1'b0;
      ex_fwd_b <= 1'b0;
    end else begin
      ex_valid <= if_valid && known_op;
      ex_write <= wr_en;
      ex_fwd_a <= fwd_a;
      ex_fwd_b <= fwd_b;
    end
  end

  always_ff @(posedge clock) begin
    ex_rd       <= rd;
    ex_alu_op   <= alu_op;
    ex_sel_pc   <= sel_pc;
    ex_sel_imm  <= sel_imm;
    ex_rs1_data <= rs1_data;
    ex_rs2_data <= rs2_data;
    ex_imm      <= imm;
    ex_pc       <= if_pc;
  end

  a_write_valid : assert property (
    @(posedge clock) disable iff (reset) ex_write |-> ex_valid
  );

endmodule

// ==== execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
  input  logic                clock,
  input  logic                reset,
  input  logic                ex_valid,
  input  core_pkg::reg_addr_t ex_rd,
  input  logic                ex_write,
  input  core_pkg::alu_op_e   ex_alu_op,
  input  logic                ex_sel_pc,
  input  logic                ex_sel_imm,
  input  logic                ex_fwd_a,
  input  logic                ex_fwd_b,
  input  core_pkg::word_t     ex_rs1_data,
  input  core_pkg::word_t     ex_rs2_data,
  input  core_pkg::word_t     ex_imm,
  input  core_pkg::word_t     ex_pc,
  output logic                wb_write,
  output core_pkg::reg_addr_t wb_rd,
  output core_pkg::word_t     wb_data,
  output logic                retire_valid,
  output core_pkg::reg_addr_t retire_rd,
  output core_pkg::word_t     retire_data,
  output core_pkg::word_t     retire_pc
);
  import core_pkg::*;

  word_t rs1_val;
  word_t rs2_val;
  word_t op_a;
  word_t op_b;
  word_t alu_result;
  word_t wb_pc;

  // --------------------------------------------------
  // Operand muxes
  // --------------------------------------------------
  assign rs1_val = ex_fwd_a ? wb_data : ex_rs1_data;  // Newest value from EX/WB
  assign rs2_val = ex_fwd_b ? wb_data : ex_rs2_data;
  assign op_a    = ex_sel_pc ? ex_pc : rs1_val;      // auipc
  assign op_b    = ex_sel_imm ? ex_imm : rs2_val;

  alu u_alu (
    .alu_op (ex_alu_op),
    .a      (op_a),
    .b      (op_b),
    .result (alu_result)
  );

  // EX/WB register
  always_ff @(posedge clock) begin
    if (reset)
      wb_write <= 1'b0;
    else
      wb_write <= ex_valid && ex_write;
  end

  always_ff @(posedge clock) begin
    wb_rd   <= ex_rd;
    wb_data <= alu_result;
    wb_pc   <= ex_pc;                                // Only kept for retire
  end

  // Retire is the writeback itself
  assign retire_valid = wb_write;
  assign retire_rd    = wb_rd;
  assign retire_data  = wb_data;
  assign retire_pc    = wb_pc;

  a_retire_rd : assert property (
    @(posedge clock) disable iff (reset) retire_valid |-> (retire_rd != '0)
  );

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
  input  logic            clock,
  input  logic            reset,
  input  core_pkg::word_t ins_mem_data,           // Read data for ins_mem_addr, same cycle
  output core_pkg::word_t ins_mem_addr,
  output logic            if_valid,
  output core_pkg::word_t if_pc,
  output core_pkg::word_t if_instr
);
  import core_pkg::*;

  word_t pc;

  // Instruction port is a plain combinational read of the PC
  assign ins_mem_addr = pc;

  // --------------------------------------------------
  // PC and IF/ID valid
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      pc       <= RESET_PC;
      if_valid <= 1'b0;
    end else begin
      pc       <= pc + PC_STEP;                   // Never stalls, never redirects
      if_valid <= 1'b1;
    end
  end

  // IF/ID payload
  always_ff @(posedge clock) begin
    if_pc    <= pc;
    if_instr <= ins_mem_data;
  end

  // Word aligned fetch only
  a_pc_aligned : assert property (
    @(posedge clock) disable iff (reset) pc[1:0] == 2'b00
  );

endmodule

// ==== list.f ====
core_pkg.sv
alu.sv
fetch_unit.sv
register_file.sv
decode_unit.sv
execute_unit.sv
core_top.sv
tb_core.sv

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic                clock,
  input  logic                reset,
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  input  logic                wb_write,
  input  core_pkg::reg_addr_t wb_rd,
  input  core_pkg::word_t     wb_data,
  output core_pkg::word_t     rs1_data,
  output core_pkg::word_t     rs2_data
);
  import core_pkg::*;

  word_t regs [NUM_REGS];

  // x0 hardwired, then bypass of the word being written
  function automatic word_t read_port(reg_addr_t addr);
    word_t value;
    if (addr == '0)
      value = '0;
    else if (wb_write && (wb_rd == addr))
      value = wb_data;                            // Covers distance two
    else
      value = regs[addr];
    return value;
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  // Write port
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++)
        regs[i] <= '0;
    end else if (wb_write) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Decode must already have filtered rd == 0
  a_no_x0_write : assert property (
    @(posedge clock) disable iff (reset) wb_write |-> (wb_rd != '0)
  );

endmodule

// ==== tb_core.sv ====
`timescale 1ns/1ps

module tb_core;
  import core_pkg::*;

  localparam int MEM_WORDS      = 256;
  localparam int NUM_KEPT       = 200;   // Kept-class instructions in the program
  localparam int RETIRE_TIMEOUT = 20;    // Cycles allowed per retire
  localparam int QUIET_CYCLES   = 10;

  logic      clock;
  logic      reset;
  word_t     ins_mem_addr;
  word_t     ins_mem_data;
  logic      retire_valid;
  reg_addr_t retire_rd;
  word_t     retire_data;
  word_t     retire_pc;

  word_t     mem [MEM_WORDS];
  word_t     model_regs [32];
  word_t     exp_pc [$];                 // Expected retires in program order
  reg_addr_t exp_rd [$];
  word_t     exp_data [$];
  word_t     next_addr;
  int        prog_words;

  core_top u_dut (
    .clock, .reset, .ins_mem_addr, .ins_mem_data,
    .retire_valid, .retire_rd, .retire_data, .retire_pc
  );

  // Memory model answers with nop outside the 1 KB window
  assign ins_mem_data = (ins_mem_addr[31:10] == '0) ? mem[ins_mem_addr[9:2]] : NOP_WORD;

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;           // 8 ns period
  end

  // --------------------------------------------------
  // Failure and compare helpers
  // --------------------------------------------------
  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_reg(string name, reg_addr_t got, reg_addr_t exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // --------------------------------------------------
  // Program generation
  // --------------------------------------------------
  function automatic reg_addr_t pick_reg();
    reg_addr_t r;
    if ($urandom_range(3, 0) == 0)
      r = reg_addr_t'($urandom_range(31, 0));
    else
      r = reg_addr_t'($urandom_range(7, 0));  // Small set for many hazards
    return r;
  endfunction

  function automatic word_t gen_kept();
    word_t      r;
    word_t      w;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [11:0] imm;
    int         kind;
    r    = $urandom;
    f3   = r[14:12];
    kind = $urandom_range(9, 0);
    f7   = (((f3 == 3'd0) || (f3 == 3'd5)) && r[30]) ? 7'b0100000 : 7'b0000000;
    if (f3 == 3'd1)
      imm = {7'b0000000, r[24:20]};           // slli
    else if (f3 == 3'd5)
      imm = {(r[30] ? 7'b0100000 : 7'b0000000), r[24:20]};
    else
      imm = r[31:20];
    if (kind < 4)
      w = {f7, pick_reg(), pick_reg(), f3, pick_reg(), 7'b0110011};
    else if (kind < 8)
      w = {imm, pick_reg(), f3, pick_reg(), 7'b0010011};
    else if (kind == 8)
      w = {r[31:12], pick_reg(), 7'b0110111}; // lui
    else
      w = {r[31:12], pick_reg(), 7'b0010111}; // auipc
    return w;
  endfunction

  // Loads, stores, branches, jumps and system
  function automatic word_t gen_unknown();
    word_t      r;
    logic [6:0] op;
    r = $urandom;
    case ($urandom_range(5, 0))
      0:       op = 7'b0000011;
      1:       op = 7'b0100011;
      2:       op = 7'b1100011;
      3:       op = 7'b1101111;
      4:       op = 7'b1100111;
      default: op = 7'b1110011;
    endcase
    return {r[31:7], op};
  endfunction

  task automatic build_program();
    int kept;
    kept       = 0;
    prog_words = 0;
    while ((kept < NUM_KEPT) && (prog_words < MEM_WORDS)) begin
      if ($urandom_range(99, 0) < 5) begin
        mem[prog_words] = gen_unknown();       // About 5% junk
      end else begin
        mem[prog_words] = gen_kept();
        kept++;
      end
      prog_words++;
    end
  endtask

  // --------------------------------------------------
  // Reference model with in-order RV32I rules
  // --------------------------------------------------
  function automatic word_t model_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
    word_t res;
    case (f3)
      3'd0: res = alt ? a - b : a + b;
      3'd1: res = a << b[4:0];
      3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: res = (a < b) ? 32'd1 : 32'd0;
      3'd4: res = a ^ b;
      3'd5: begin
        if (alt)
          res = $signed(a) >>> b[4:0];
        else
          res = a >> b[4:0];
      end
      3'd6: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  task automatic run_model();
    word_t      w;
    word_t      pc;
    word_t      value;
    reg_addr_t  rd;
    logic [2:0] f3;
    logic       writes;
    for (int i = 0; i < prog_words; i++) begin
      w      = mem[i];
      pc     = i * 4;
      rd     = w[11:7];
      f3     = w[14:12];
      writes = 1'b1;
      value  = '0;
      case (w[6:0])
        7'b0110011: value = model_alu(f3, w[30] && ((f3 == 3'd0) || (f3 == 3'd5)),
                                      model_regs[w[19:15]], model_regs[w[24:20]]);
        7'b0010011: value = model_alu(f3, w[30] && (f3 == 3'd5),
                                      model_regs[w[19:15]], {{20{w[31]}}, w[31:20]});
        7'b0110111: value = {w[31:12], 12'h000};
        7'b0010111: value = pc + {w[31:12], 12'h000};
        default:    writes = 1'b0;             // No retire
      endcase
      if (writes && (rd != '0)) begin
        model_regs[rd] = value;
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_data.push_back(value);
      end
    end
  endtask

  // --------------------------------------------------
  // Retire checks
  // --------------------------------------------------
  task automatic wait_retire(int idx);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && (cycles < RETIRE_TIMEOUT)) begin
      @(negedge clock);
      if (retire_valid === 1'b1)
        seen = 1'b1;
      else
        cycles++;
    end
    if (!seen) begin
      $display("Timeout: retire %0d for pc 0x%h did not appear within %0d cycles",
               idx, exp_pc[idx], RETIRE_TIMEOUT);
      abort_run();
    end else begin
      check_word("retire_pc", retire_pc, exp_pc[idx]);
      check_reg("retire_rd", retire_rd, exp_rd[idx]);
      check_word("retire_data", retire_data, exp_data[idx]);
    end
  endtask

  task automatic expect_quiet();
    int   n;
    logic extra;
    n     = 0;
    extra = 1'b0;
    while (!extra && (n < QUIET_CYCLES)) begin
      @(negedge clock);
      extra = (retire_valid !== 1'b0);
      n++;
    end
    if (extra) begin
      $display("Unexpected retire after the last expected one, pc 0x%h", retire_pc);
      abort_run();
    end
  endtask

  // Fetch address steps by one word each cycle out of reset
  always @(negedge clock) begin
    if (reset === 1'b0) begin
      check_word("ins_mem_addr", ins_mem_addr, next_addr);
      next_addr = next_addr + 32'd4;
    end
  end

  initial begin
    reset     = 1'b1;
    next_addr = '0;
    void'($urandom(32'hc40f));
    foreach (mem[i])
      mem[i] = NOP_WORD;
    foreach (model_regs[i])
      model_regs[i] = '0;
    build_program();
    run_model();
    repeat (4) @(posedge clock);
    #1 reset = 1'b0;
    @(negedge clock);
    check_flag("retire_valid", retire_valid, 1'b0);   // Pipeline empty
    for (int i = 0; i < exp_pc.size(); i++)
      wait_retire(i);
    expect_quiet();
    $display("sim passed");
    $finish;
  end

endmodule
